/* build.f */
+incdir+logic
logic/procCtrlPkg.sv
logic/opcodeDecoder.sv
logic/stateSequencer.sv
logic/controlWordGen.sv
logic/multiCycleControl.sv
verif/clockGen.sv
verif/multiCycleControlTb.sv

/* logic/controlWordGen.sv */
`timescale 1ns/100ps

module controlWordGen
	import procCtrlPkg::*;
(
	input  ctrlState_t state,
	input  opcode_t    curOp,        // opcode latched at decode
	input  logic       flagN,        // negative flag
	input  logic       flagZ,        // zero flag
	output logic       pcWrite,
	output logic       addrSel,      // 1 selects pc as memory address
	output logic       memRead,
	output logic       memWrite,
	output logic       irLoad,
	output logic       opASel,       // 1 steers r1 into operand A
	output logic       mdrLoad,
	output logic       opABLoad,
	output logic       alu1Sel,      // 1 selects operand A over pc
	output logic       aluOutWrite,
	output logic       rfWrite,
	output logic       regIn,        // 1 writes mdr instead of alu out
	output logic       flagWrite,
	output aluBSel_t   alu2Sel,
	output aluOp_t     aluOp
);

	always_comb
	begin
		// --------------------
		// inactive word
		// --------------------
		pcWrite     = 1'b0;
		addrSel     = 1'b0;
		memRead     = 1'b0;
		memWrite    = 1'b0;
		irLoad      = 1'b0;
		opASel      = 1'b0;
		mdrLoad     = 1'b0;
		opABLoad    = 1'b0;
		alu1Sel     = 1'b0;
		aluOutWrite = 1'b0;
		rfWrite     = 1'b0;
		regIn       = 1'b0;
		flagWrite   = 1'b0;
		alu2Sel     = bRegB;
		aluOp       = aluAdd;

		// --------------------
		// per state controls
		// --------------------
		case (state)
			fetchS:
			begin
				pcWrite = 1'b1;                     // pc + 1 back into pc
				addrSel = 1'b1;                     // instruction at pc
				memRead = 1'b1;
				irLoad  = 1'b1;
				alu2Sel = bOne;                     // increment
			end
			decodeS:
			begin
				opABLoad = 1'b1;                    // read both registers
			end
			aluExecS:
			begin
				alu1Sel     = 1'b1;
				aluOutWrite = 1'b1;
				flagWrite   = 1'b1;                 // n and z from result
				case (curOp)
					opSub:   aluOp = aluSub;
					opNand:  aluOp = aluNand;
					default: aluOp = aluAdd;
				endcase
			end
			shiftExecS:
			begin
				alu1Sel     = 1'b1;
				aluOutWrite = 1'b1;
				flagWrite   = 1'b1;
				alu2Sel     = bImm3;                // shift amount from IR
				aluOp       = aluShift;
			end
			regWriteS:
			begin
				rfWrite = 1'b1;                     // alu out into r1
			end
			oriLoadS:
			begin
				opASel   = 1'b1;                    // ori always works on r1
				opABLoad = 1'b1;
			end
			oriExecS:
			begin
				alu1Sel     = 1'b1;
				aluOutWrite = 1'b1;
				flagWrite   = 1'b1;
				alu2Sel     = bImm5;
				aluOp       = aluOr;
			end
			oriWriteS:
			begin
				opASel  = 1'b1;                     // destination is r1
				rfWrite = 1'b1;
			end
			loadReadS:
			begin
				memRead = 1'b1;                     // address from operand B
				mdrLoad = 1'b1;
			end
			loadWriteS:
			begin
				aluOutWrite = 1'b1;
				rfWrite     = 1'b1;
				regIn       = 1'b1;                 // mdr into register
			end
			storeS:
			begin
				memWrite = 1'b1;
			end
			branchS:
			begin
				alu2Sel = bImm4;                    // pc + offset
				case (curOp)
					opBpz:   pcWrite = ~flagN;
					opBz:    pcWrite = flagZ;
					opBnz:   pcWrite = ~flagZ;
					default: pcWrite = 1'b0;
				endcase
			end
			default: ;                              // resetS keeps the idle word
		endcase
	end

endmodule

/* logic/ctrl_defines.svh */
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// --------------------
// field widths
// --------------------
`define INSTR_WIDTH    4    // opcode field of the IR
`define ALU_SEL_WIDTH  3    // alu operation and alu B mux select
`define STATE_WIDTH    5    // room for up to 32 states

// --------------------
// full opcode patterns
// --------------------
`define OP_LOAD   4'b0000
`define OP_STORE  4'b0010
`define OP_ADD    4'b0100
`define OP_SUB    4'b0110
`define OP_NAND   4'b1000
`define OP_BPZ    4'b1101   // branch if not negative
`define OP_BZ     4'b0101   // branch if zero
`define OP_BNZ    4'b1001   // branch if not zero

// shift and ori ignore the top bit which carries an operand
`define OP_SHIFT_LOW  3'b011
`define OP_ORI_LOW    3'b111

`endif

/* logic/multiCycleControl.sv */
`timescale 1ns/100ps
`include "ctrl_defines.svh"

module multiCycleControl
	import procCtrlPkg::*;
(
	input  logic                    clock,
	input  logic                    reset,
	input  logic [`INSTR_WIDTH-1:0] instr,   // IR opcode field
	input  logic                    flagN,
	input  logic                    flagZ,
	output logic                    pcWrite,
	output logic                    addrSel,
	output logic                    memRead,
	output logic                    memWrite,
	output logic                    irLoad,
	output logic                    opASel,
	output logic                    mdrLoad,
	output logic                    opABLoad,
	output logic                    alu1Sel,
	output logic                    aluOutWrite,
	output logic                    rfWrite,
	output logic                    regIn,
	output logic                    flagWrite,
	output aluBSel_t                alu2Sel,
	output aluOp_t                  aluOp
);

	opcode_t    decodedOp;   // combinational decode of instr
	ctrlState_t state;
	opcode_t    curOp;       // held from decode onward

	// --------------------
	// decode, sequence, drive
	// --------------------
	opcodeDecoder uDecoder
	(
		.instr     (instr),
		.decodedOp (decodedOp)
	);

	stateSequencer uSequencer
	(
		.clock     (clock),
		.reset     (reset),
		.decodedOp (decodedOp),
		.state     (state),
		.curOp     (curOp)
	);

	controlWordGen uControlWord
	(
		.state (state), .curOp (curOp), .flagN (flagN), .flagZ (flagZ),
		.pcWrite (pcWrite), .addrSel (addrSel), .memRead (memRead),
		.memWrite (memWrite), .irLoad (irLoad), .opASel (opASel),
		.mdrLoad (mdrLoad), .opABLoad (opABLoad), .alu1Sel (alu1Sel),
		.aluOutWrite (aluOutWrite), .rfWrite (rfWrite), .regIn (regIn),
		.flagWrite (flagWrite), .alu2Sel (alu2Sel), .aluOp (aluOp)
	);

endmodule

/* logic/opcodeDecoder.sv */
`timescale 1ns/100ps
`include "ctrl_defines.svh"

module opcodeDecoder
	import procCtrlPkg::*;
(
	input  logic [`INSTR_WIDTH-1:0] instr,     // raw IR opcode field
	output opcode_t                 decodedOp  // instruction class
);

	// --------------------
	// priority table
	// --------------------
	always_comb
	begin
		decodedOp = opIllegal;                      // unmatched patterns
		if (instr == `OP_ADD)
			decodedOp = opAdd;
		else if (instr == `OP_SUB)
			decodedOp = opSub;
		else if (instr == `OP_NAND)
			decodedOp = opNand;
		else if (instr[2:0] == `OP_SHIFT_LOW)
			decodedOp = opShift;                    // top bit is shift direction
		else if (instr[2:0] == `OP_ORI_LOW)
			decodedOp = opOri;                      // top bit is part of imm5
		else if (instr == `OP_LOAD)
			decodedOp = opLoad;
		else if (instr == `OP_STORE)
			decodedOp = opStore;
		else if (instr == `OP_BPZ)
			decodedOp = opBpz;
		else if (instr == `OP_BZ)
			decodedOp = opBz;
		else if (instr == `OP_BNZ)
			decodedOp = opBnz;
	end

endmodule

/* logic/procCtrlPkg.sv */
`include "ctrl_defines.svh"

package procCtrlPkg;

	// --------------------
	// sequencer states
	// --------------------
	typedef enum logic [`STATE_WIDTH-1:0]
	{
		resetS,         // idle word entered on reset or bad opcode
		fetchS,         // cycle 1 of every instruction
		decodeS,        // cycle 2 where operands are latched
		aluExecS,       // add sub nand
		regWriteS,      // writeback for alu and shift
		shiftExecS,
		oriLoadS,       // r1 into operand A
		oriExecS,
		oriWriteS,
		loadReadS,      // memory into mdr
		loadWriteS,     // mdr into register file
		storeS,
		branchS         // one state for all three branches
	} ctrlState_t;

	// decoded instruction classes
	typedef enum logic [3:0]
	{
		opLoad,
		opStore,
		opAdd,
		opSub,
		opNand,
		opShift,
		opOri,
		opBpz,
		opBz,
		opBnz,
		opIllegal       // anything the decoder does not know
	} opcode_t;

	// --------------------
	// datapath selects
	// --------------------
	typedef enum logic [`ALU_SEL_WIDTH-1:0]
	{
		aluAdd   = 3'd0,
		aluSub   = 3'd1,
		aluOr    = 3'd2,
		aluNand  = 3'd3,
		aluShift = 3'd4
	} aluOp_t;

	typedef enum logic [`ALU_SEL_WIDTH-1:0]
	{
		bRegB = 3'd0,   // operand B register
		bOne  = 3'd1,   // constant one for pc increment
		bImm4 = 3'd2,   // branch offset
		bImm5 = 3'd3,   // ori immediate
		bImm3 = 3'd4    // shift amount
	} aluBSel_t;

endpackage

/* logic/stateSequencer.sv */
`timescale 1ns/100ps

module stateSequencer
	import procCtrlPkg::*;
(
	input  logic       clock,
	input  logic       reset,      // async, active high
	input  opcode_t    decodedOp,  // live decode of the IR
	output ctrlState_t state,      // current sequencer state
	output opcode_t    curOp       // opcode held for the execute cycles
);

	ctrlState_t nextState;

	// --------------------
	// successor rules
	// --------------------
	always_comb
	begin
		nextState = resetS;                         // unknown states recover here
		case (state)
			resetS:     nextState = fetchS;
			fetchS:     nextState = decodeS;
			decodeS:
			begin
				case (decodedOp)
					opAdd, opSub, opNand: nextState = aluExecS;
					opShift:              nextState = shiftExecS;
					opOri:                nextState = oriLoadS;
					opLoad:               nextState = loadReadS;
					opStore:              nextState = storeS;
					opBpz, opBz, opBnz:   nextState = branchS;
					default:              nextState = resetS;     // illegal opcode
				endcase
			end
			aluExecS:   nextState = regWriteS;
			shiftExecS: nextState = regWriteS;      // shares the alu writeback
			regWriteS:  nextState = fetchS;
			oriLoadS:   nextState = oriExecS;
			oriExecS:   nextState = oriWriteS;
			oriWriteS:  nextState = fetchS;
			loadReadS:  nextState = loadWriteS;
			loadWriteS: nextState = fetchS;
			storeS:     nextState = fetchS;
			branchS:    nextState = fetchS;
			default:    nextState = resetS;
		endcase
	end

	// --------------------
	// state and opcode registers
	// --------------------
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= resetS;
			curOp <= opIllegal;
		end
		else
		begin
			state <= nextState;
			if (state == decodeS)
				curOp <= decodedOp;                 // frozen until next decode
		end
	end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module multiCycleControlTb -o simv

output=$(./obj_dir/simv)
echo "$output"

if echo "$output" | grep -qx "Simulation PASSED"; then
	exit 0
fi
exit 1

/* verif/clockGen.sv */
`timescale 1ns/100ps

module clockGen
(
	output logic clock,
	output logic reset
);

	localparam int halfPeriod  = 5;   // 10 ns clock
	localparam int resetCycles = 4;

	initial
	begin
		clock = 1'b0;
		forever #halfPeriod clock = ~clock;
	end

	initial
	begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clock);
		reset <= 1'b0;                    // released on a rising edge
	end

endmodule

/* verif/multiCycleControlTb.sv */
`timescale 1ns/100ps
`include "ctrl_defines.svh"

module multiCycleControlTb
	import procCtrlPkg::*;
();

	localparam int cycleLimit = 2000;     // tests need about 100 cycles

	logic clock, reset;
	logic [`INSTR_WIDTH-1:0] instr;
	logic flagN, flagZ;
	logic pcWrite, addrSel, memRead, memWrite, irLoad, opASel, mdrLoad;
	logic opABLoad, alu1Sel, aluOutWrite, rfWrite, regIn, flagWrite;
	aluBSel_t alu2Sel;
	aluOp_t aluOp;

	// one-bit controls with pcWrite on the left down to flagWrite on the right
	logic [12:0] actBits, expBits;
	string bitNames [12:0] = '{"pcWrite", "addrSel", "memRead", "memWrite", "irLoad",
		"opASel", "mdrLoad", "opABLoad", "alu1Sel", "aluOutWrite", "rfWrite", "regIn",
		"flagWrite"};
	aluBSel_t expAlu2Sel;
	aluOp_t expAluOp;
	int bitErrors, aluOpErrors, bSelErrors, totalErrors, cycleCount;
	logic [15:0] lfsrState;

	clockGen clocks (.clock(clock), .reset(reset));

	multiCycleControl dut
	(
		.clock(clock), .reset(reset), .instr(instr), .flagN(flagN), .flagZ(flagZ),
		.pcWrite(pcWrite), .addrSel(addrSel), .memRead(memRead), .memWrite(memWrite),
		.irLoad(irLoad), .opASel(opASel), .mdrLoad(mdrLoad), .opABLoad(opABLoad),
		.alu1Sel(alu1Sel), .aluOutWrite(aluOutWrite), .rfWrite(rfWrite), .regIn(regIn),
		.flagWrite(flagWrite), .alu2Sel(alu2Sel), .aluOp(aluOp)
	);

	assign actBits = {pcWrite, addrSel, memRead, memWrite, irLoad, opASel, mdrLoad,
		opABLoad, alu1Sel, aluOutWrite, rfWrite, regIn, flagWrite};

	// --------------------
	// flag source
	// --------------------
	function automatic logic [15:0] lfsrNext(input logic [15:0] cur);
		lfsrNext = cur >> 1;
		if (cur[0])
			lfsrNext = lfsrNext ^ 16'hB400;   // x^16 + x^14 + x^13 + x^11 + 1
	endfunction

	task automatic randomBit(output logic b);
		lfsrState = lfsrNext(lfsrState);  // one step per bit
		b = lfsrState[0];
	endtask

	// --------------------
	// reference word
	// --------------------
	task automatic expectWord(input ctrlState_t st, input opcode_t op, input logic n,
		input logic z);
		logic taken;
		taken = (op == opBpz) ? ~n : ((op == opBz) ? z : ~z);
		case (st)
			fetchS:     expBits = 13'b1_1_1_0_1_0_0_0_0_0_0_0_0;
			decodeS:    expBits = 13'b0_0_0_0_0_0_0_1_0_0_0_0_0;
			aluExecS:   expBits = 13'b0_0_0_0_0_0_0_0_1_1_0_0_1;
			shiftExecS: expBits = 13'b0_0_0_0_0_0_0_0_1_1_0_0_1;
			regWriteS:  expBits = 13'b0_0_0_0_0_0_0_0_0_0_1_0_0;
			oriLoadS:   expBits = 13'b0_0_0_0_0_1_0_1_0_0_0_0_0;
			oriExecS:   expBits = 13'b0_0_0_0_0_0_0_0_1_1_0_0_1;
			oriWriteS:  expBits = 13'b0_0_0_0_0_1_0_0_0_0_1_0_0;
			loadReadS:  expBits = 13'b0_0_1_0_0_0_1_0_0_0_0_0_0;
			loadWriteS: expBits = 13'b0_0_0_0_0_0_0_0_0_1_1_1_0;
			storeS:     expBits = 13'b0_0_0_1_0_0_0_0_0_0_0_0_0;
			branchS:    expBits = {taken, 12'b0};     // only pcWrite can rise
			default:    expBits = '0;                 // idle word
		endcase
		case (st)
			fetchS:     expAlu2Sel = bOne;
			shiftExecS: expAlu2Sel = bImm3;
			oriExecS:   expAlu2Sel = bImm5;
			branchS:    expAlu2Sel = bImm4;
			default:    expAlu2Sel = bRegB;
		endcase
		case (st)
			aluExecS:   expAluOp = (op == opSub) ? aluSub : ((op == opNand) ? aluNand : aluAdd);
			shiftExecS: expAluOp = aluShift;
			oriExecS:   expAluOp = aluOr;
			default:    expAluOp = aluAdd;
		endcase
	endtask

	// --------------------
	// compare tasks
	// --------------------
	task automatic checkBit(input string testName, input string sigName,
		input logic expected, input logic actual);
		if (actual !== expected)
		begin
			bitErrors++;
			$display("Error %s: %s expected %0b actual %0b", testName, sigName,
				expected, actual);
		end
	endtask

	task automatic checkAluOp(input string testName, input aluOp_t expected,
		input aluOp_t actual);
		if (actual !== expected)
		begin
			aluOpErrors++;
			$display("Error %s: aluOp expected %s (%0d) actual %s (%0d)", testName,
				expected.name(), expected, actual.name(), actual);
		end
	endtask

	task automatic checkBSel(input string testName, input aluBSel_t expected,
		input aluBSel_t actual);
		if (actual !== expected)
		begin
			bSelErrors++;
			$display("Error %s: alu2Sel expected %s (%0d) actual %s (%0d)", testName,
				expected.name(), expected, actual.name(), actual);
		end
	endtask

	task automatic compareWord(input string testName);
		logic [3:0] k;
		for (k = 4'd0; k < 4'd13; k++)
			checkBit(testName, bitNames[k], expBits[k], actBits[k]);
		checkBSel(testName, expAlu2Sel, alu2Sel);
		checkAluOp(testName, expAluOp, aluOp);
	endtask

	task automatic checkCycle(input string testName, input ctrlState_t st, input opcode_t op);
		@(negedge clock);                 // word settled by mid-cycle
		expectWord(st, op, 1'b0, 1'b0);
		compareWord(testName);
	endtask

	// --------------------
	// instruction drivers
	// --------------------
	task automatic runInstr(input string testName, input logic [3:0] bits, input opcode_t op,
		input int execCycles, input ctrlState_t s0, input ctrlState_t s1, input ctrlState_t s2);
		checkCycle(testName, fetchS, op);
		@(posedge clock);
		instr <= bits;                    // IR loads at the end of fetch
		checkCycle(testName, decodeS, op);
		checkCycle(testName, s0, op);
		if (execCycles > 1)
			checkCycle(testName, s1, op);
		if (execCycles > 2)
			checkCycle(testName, s2, op);
	endtask

	task automatic runBranch(input string testName, input logic [3:0] bits, input opcode_t op);
		logic n, z;
		checkCycle(testName, fetchS, op);
		@(posedge clock);
		instr <= bits;
		checkCycle(testName, decodeS, op);
		randomBit(n);
		randomBit(z);
		@(posedge clock);
		flagN <= n;                       // flags valid for the branch cycle
		flagZ <= z;
		@(negedge clock);
		expectWord(branchS, op, n, z);
		compareWord(testName);
		flagN <= ~n;                      // flip both and the condition must follow
		flagZ <= ~z;
		#2;
		expectWord(branchS, op, ~n, ~z);
		compareWord({testName, " flags changed"});
	endtask

	// --------------------
	// directed tests
	// --------------------
	task automatic testReset();
		do
		begin
			@(negedge clock);
			expectWord(resetS, opIllegal, 1'b0, 1'b0);
			compareWord("reset");
		end
		while (reset);                    // one idle cycle after release too
	endtask

	task automatic testAluOps();
		runInstr("add", `OP_ADD, opAdd, 2, aluExecS, regWriteS, resetS);
		runInstr("sub", `OP_SUB, opSub, 2, aluExecS, regWriteS, resetS);
		runInstr("nand", `OP_NAND, opNand, 2, aluExecS, regWriteS, resetS);
	endtask

	task automatic testShiftOri();
		runInstr("shift top 0", {1'b0, `OP_SHIFT_LOW}, opShift, 2, shiftExecS, regWriteS, resetS);
		runInstr("shift top 1", {1'b1, `OP_SHIFT_LOW}, opShift, 2, shiftExecS, regWriteS, resetS);
		runInstr("ori top 0", {1'b0, `OP_ORI_LOW}, opOri, 3, oriLoadS, oriExecS, oriWriteS);
		runInstr("ori top 1", {1'b1, `OP_ORI_LOW}, opOri, 3, oriLoadS, oriExecS, oriWriteS);
	endtask

	task automatic testLoadStore();
		runInstr("load", `OP_LOAD, opLoad, 2, loadReadS, loadWriteS, resetS);
		runInstr("store", `OP_STORE, opStore, 1, storeS, resetS, resetS);
	endtask

	task automatic testBranches();
		repeat (4)
		begin
			runBranch("bpz", `OP_BPZ, opBpz);
			runBranch("bz", `OP_BZ, opBz);
			runBranch("bnz", `OP_BNZ, opBnz);
		end
	endtask

	task automatic testIllegal();
		runInstr("illegal 1110", 4'b1110, opIllegal, 1, resetS, resetS, resetS);
		runInstr("illegal 1100", 4'b1100, opIllegal, 1, resetS, resetS, resetS);
		runInstr("illegal 0001", 4'b0001, opIllegal, 1, resetS, resetS, resetS);
		runInstr("illegal 1010", 4'b1010, opIllegal, 1, resetS, resetS, resetS);
	endtask

	// --------------------
	// run control
	// --------------------
	initial
	begin
		cycleCount = 0;
		while (cycleCount < cycleLimit)
		begin
			@(posedge clock);
			cycleCount++;
		end
		$display("Timeout: the tests did not finish within %0d clock cycles", cycleLimit);
		$display("Simulation FAILED");
		$finish;
	end

	initial
	begin
		instr = `OP_LOAD;
		flagN = 1'b0;
		flagZ = 1'b0;
		bitErrors = 0;
		aluOpErrors = 0;
		bSelErrors = 0;
		lfsrState = 16'd42013;            // seed
		testReset();
		testAluOps();
		testShiftOri();
		testLoadStore();
		testBranches();
		testIllegal();
		checkCycle("refetch", fetchS, opIllegal);    // last instruction returns to fetch
		totalErrors = bitErrors + aluOpErrors + bSelErrors;
		$display("Summary: control bit errors %0d, aluOp errors %0d, alu2Sel errors %0d, total %0d",
			bitErrors, aluOpErrors, bSelErrors, totalErrors);
		if (totalErrors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
